// File: vmem_macros.svh
/*
 * bus, address and vector id widths
 * depth of the response tag queue
 */
`ifndef VMEM_MACROS_SVH
`define VMEM_MACROS_SVH

// memory bus and vector port share this width
`define VMEM_BUS_W 64

`define VMEM_ADDR_W 32

// vector request id
`define VMEM_ID_W 3

// max outstanding bus requests
`define VMEM_RSP_DEPTH 16

`endif

// File: vmem_bus_pkg.sv
/*
 * data types of the memory bus and the scalar and vector ports
 */
`default_nettype none

`include "vmem_macros.svh"

package vmem_bus_pkg;

    typedef logic [`VMEM_ADDR_W-1:0]   addr_t;
    typedef logic [31:0]               word_t;   // scalar word
    typedef logic [`VMEM_BUS_W-1:0]    line_t;   // one bus beat
    typedef logic [`VMEM_BUS_W/8-1:0]  be_t;
    typedef logic [`VMEM_ID_W-1:0]     vid_t;

    // one extra bit so that a full tag queue can be counted
    typedef logic [$clog2(`VMEM_RSP_DEPTH+1)-1:0] cnt_t;

endpackage

`default_nettype wire

// File: vmem_ctrl_pkg.sv
/*
 * data port ownership state and bus request kinds
 */
`default_nettype none

package vmem_ctrl_pkg;

    // bit 0 marks a scalar owner, bit 1 a vector owner
    typedef enum logic [1:0] {
        DP_IDLE   = 2'b00,
        DP_SCALAR = 2'b01,
        DP_VECTOR = 2'b10,
        DP_BOTH   = 2'b11
    } dport_state_e;

    // kind of a granted bus request, kept in the tag queue
    typedef enum logic [1:0] {
        OP_IFETCH = 2'b00,
        OP_DLOAD  = 2'b01,
        OP_DSTORE = 2'b10
    } mem_op_e;

endpackage

`default_nettype wire

// File: dport_mux.sv
/*
 * merge of scalar and vector data requests onto one data port
 */
`timescale 1ns/1ps
`default_nettype none

module dport_mux (
    input  wire logic                 sdata_req_i,
    input  wire vmem_bus_pkg::addr_t  sdata_addr_i,
    input  wire logic                 sdata_we_i,
    input  wire logic [3:0]           sdata_be_i,
    input  wire vmem_bus_pkg::word_t  sdata_wdata_i,

    input  wire logic                 vdata_req_i,
    input  wire vmem_bus_pkg::addr_t  vdata_addr_i,
    input  wire logic                 vdata_we_i,
    input  wire vmem_bus_pkg::be_t    vdata_be_i,
    input  wire vmem_bus_pkg::line_t  vdata_wdata_i,

    input  wire logic                 pending_load_i,
    input  wire logic                 pending_store_i,

    input  wire logic                 data_gnt_i,
    output logic                      data_req_o,
    output vmem_bus_pkg::addr_t       data_addr_o,
    output logic                      data_we_o,
    output vmem_bus_pkg::be_t         data_be_o,
    output vmem_bus_pkg::line_t       data_wdata_o,

    output logic                      sdata_gnt_o,
    output logic                      vdata_gnt_o
);
    import vmem_bus_pkg::*;

    logic sdata_hold;
    be_t  sdata_be_lane;

    // scalar waits behind vector traffic, stores also behind pending loads
    assign sdata_hold = vdata_req_i | pending_store_i | (pending_load_i & sdata_we_i);

    // addr bit 2 picks the upper word of the beat
    assign sdata_be_lane = sdata_addr_i[2] ? {sdata_be_i, 4'b0000} : {4'b0000, sdata_be_i};

    assign data_req_o = vdata_req_i | (sdata_req_i & ~sdata_hold);

    always_comb begin
        if (vdata_req_i) begin
            data_addr_o  = vdata_addr_i;
            data_we_o    = vdata_we_i;
            data_be_o    = vdata_be_i;
            data_wdata_o = vdata_wdata_i;
        end else begin
            data_addr_o  = sdata_addr_i;
            data_we_o    = sdata_we_i;
            data_be_o    = sdata_be_lane;
            data_wdata_o = {sdata_wdata_i, sdata_wdata_i};   // both lanes, be selects
        end
    end

    assign sdata_gnt_o = data_gnt_i & sdata_req_i & ~sdata_hold;
    assign vdata_gnt_o = data_gnt_i & vdata_req_i;

endmodule

`default_nettype wire

// File: dport_wait_fsm.sv
/*
 * ownership tracking of outstanding data responses
 * routing of data responses to the scalar or vector port
 */
`timescale 1ns/1ps
`default_nettype none

module dport_wait_fsm (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,

    input  wire logic                 sdata_gnt_i,
    input  wire logic                 vdata_gnt_i,
    input  wire vmem_bus_pkg::addr_t  sdata_addr_i,
    input  wire vmem_bus_pkg::vid_t   vdata_id_i,

    input  wire logic                 data_rvalid_i,
    input  wire vmem_bus_pkg::line_t  data_rdata_i,

    output logic                      sdata_rvalid_o,
    output vmem_bus_pkg::word_t       sdata_rdata_o,
    output logic                      vdata_rvalid_o,
    output vmem_bus_pkg::line_t       vdata_rdata_o,
    output vmem_bus_pkg::vid_t        vdata_rid_o
);
    import vmem_bus_pkg::*;
    import vmem_ctrl_pkg::*;

    dport_state_e state_q, state_d;
    logic         s_own, v_own;
    logic         s_next, v_next;
    logic         sdata_lane_q;   // addr bit 2 of the granted scalar request
    vid_t         vdata_id_q;

    assign s_own = (state_q == DP_SCALAR) || (state_q == DP_BOTH);
    assign v_own = (state_q == DP_VECTOR) || (state_q == DP_BOTH);

    // a new grant wins over a response in the same cycle
    assign s_next = sdata_gnt_i | (s_own & ~data_rvalid_i);
    assign v_next = vdata_gnt_i | (v_own & ~data_rvalid_i);

    always_comb begin
        case ({v_next, s_next})
            2'b01:   state_d = DP_SCALAR;
            2'b10:   state_d = DP_VECTOR;
            2'b11:   state_d = DP_BOTH;
            default: state_d = DP_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= DP_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sdata_gnt_i) sdata_lane_q <= sdata_addr_i[2];
        if (vdata_gnt_i) vdata_id_q   <= vdata_id_i;
    end

    //////////////////////
    // response routing
    assign sdata_rvalid_o = data_rvalid_i & s_own;
    assign vdata_rvalid_o = data_rvalid_i & v_own;

    assign sdata_rdata_o = sdata_lane_q ? data_rdata_i[63:32] : data_rdata_i[31:0];
    assign vdata_rdata_o = data_rdata_i;
    assign vdata_rid_o   = vdata_id_q;

endmodule

`default_nettype wire

// File: req_counter.sv
/*
 * counter of outstanding bus requests
 */
`timescale 1ns/1ps
`default_nettype none

module req_counter (
    input  wire logic           clk_i,
    input  wire logic           rst_ni,
    input  wire logic           push_i,   // request granted
    input  wire logic           pop_i,    // response seen
    output vmem_bus_pkg::cnt_t  count_o
);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_o <= '0;
        end else begin
            case ({push_i, pop_i})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;   // idle, or one in and one out
            endcase
        end
    end

endmodule

`default_nettype wire

// File: bus_arbiter.sv
/*
 * arbiter between data port and instruction fetch on the memory bus
 * response tag queue and response routing
 */
`timescale 1ns/1ps
`default_nettype none

`include "vmem_macros.svh"

module bus_arbiter (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,

    input  wire logic                 instr_req_i,
    input  wire vmem_bus_pkg::addr_t  instr_addr_i,
    output logic                      instr_gnt_o,
    output logic                      instr_rvalid_o,
    output vmem_bus_pkg::word_t       instr_rdata_o,

    input  wire logic                 data_req_i,
    input  wire vmem_bus_pkg::addr_t  data_addr_i,
    input  wire logic                 data_we_i,
    input  wire vmem_bus_pkg::be_t    data_be_i,
    input  wire vmem_bus_pkg::line_t  data_wdata_i,
    output logic                      data_gnt_o,
    output logic                      data_rvalid_o,
    output vmem_bus_pkg::line_t       data_rdata_o,

    output logic                      err_o,

    output logic                      mem_req_o,
    output vmem_bus_pkg::addr_t       mem_addr_o,
    output logic                      mem_we_o,
    output vmem_bus_pkg::be_t         mem_be_o,
    output vmem_bus_pkg::line_t       mem_wdata_o,
    input  wire logic                 mem_rvalid_i,
    input  wire logic                 mem_err_i,
    input  wire vmem_bus_pkg::line_t  mem_rdata_i
);
    import vmem_bus_pkg::*;
    import vmem_ctrl_pkg::*;

    logic    push, pop;
    mem_op_e push_op;
    cnt_t    req_cnt;
    cnt_t    wr_idx;

    // tag queue, entry 0 belongs to the oldest outstanding request
    mem_op_e op_q   [`VMEM_RSP_DEPTH];
    logic    lane_q [`VMEM_RSP_DEPTH];   // fetch addr bit 2

    //////////////////////
    // request side
    assign data_gnt_o  = data_req_i;
    assign instr_gnt_o = instr_req_i & ~data_req_i;   // data always wins

    assign mem_req_o = instr_req_i | data_req_i;

    always_comb begin
        if (data_req_i) begin
            mem_addr_o = data_addr_i;
            mem_we_o   = data_we_i;
            mem_be_o   = data_be_i;
        end else begin
            mem_addr_o = instr_addr_i;
            mem_we_o   = 1'b0;
            mem_be_o   = '1;
        end
    end
    assign mem_wdata_o = data_wdata_i;

    //////////////////////
    // tag queue
    assign push = instr_gnt_o | data_gnt_o;
    assign pop  = mem_rvalid_i;

    assign push_op = !data_gnt_o ? OP_IFETCH : (data_we_i ? OP_DSTORE : OP_DLOAD);

    // head leaves in the same cycle, so the new tag goes one slot lower
    assign wr_idx = pop ? req_cnt - 1'b1 : req_cnt;

    req_counter u_req_counter (
        .clk_i   ( clk_i   ),
        .rst_ni  ( rst_ni  ),
        .push_i  ( push    ),
        .pop_i   ( pop     ),
        .count_o ( req_cnt )
    );

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `VMEM_RSP_DEPTH - 1; i++) begin
            if (push && wr_idx == cnt_t'(i)) begin
                op_q[i]   <= push_op;
                lane_q[i] <= instr_addr_i[2];
            end else if (pop) begin
                op_q[i]   <= op_q[i+1];
                lane_q[i] <= lane_q[i+1];
            end
        end
        // last slot has nothing above it to shift in
        if (push && wr_idx == cnt_t'(`VMEM_RSP_DEPTH - 1)) begin
            op_q[`VMEM_RSP_DEPTH-1]   <= push_op;
            lane_q[`VMEM_RSP_DEPTH-1] <= instr_addr_i[2];
        end
    end

    //////////////////////
    // response side
    assign instr_rvalid_o = mem_rvalid_i & (op_q[0] == OP_IFETCH);
    assign data_rvalid_o  = mem_rvalid_i & ((op_q[0] == OP_DLOAD) || (op_q[0] == OP_DSTORE));

    assign instr_rdata_o = lane_q[0] ? mem_rdata_i[63:32] : mem_rdata_i[31:0];
    assign data_rdata_o  = mem_rdata_i;
    assign err_o         = mem_err_i;

endmodule

`default_nettype wire

// File: vmem_top.sv
/*
 * memory side of the vector coprocessor system
 * fetch, scalar data and vector data ports on one memory bus
 */
`timescale 1ns/1ps
`default_nettype none

module vmem_top (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,

    // instruction fetch
    input  wire logic                 instr_req_i,
    input  wire vmem_bus_pkg::addr_t  instr_addr_i,
    output logic                      instr_gnt_o,
    output logic                      instr_rvalid_o,
    output vmem_bus_pkg::word_t       instr_rdata_o,
    output logic                      instr_err_o,

    // scalar data
    input  wire logic                 sdata_req_i,
    input  wire vmem_bus_pkg::addr_t  sdata_addr_i,
    input  wire logic                 sdata_we_i,
    input  wire logic [3:0]           sdata_be_i,
    input  wire vmem_bus_pkg::word_t  sdata_wdata_i,
    output logic                      sdata_gnt_o,
    output logic                      sdata_rvalid_o,
    output vmem_bus_pkg::word_t       sdata_rdata_o,
    output logic                      sdata_err_o,

    // vector data
    input  wire logic                 vdata_req_i,
    input  wire vmem_bus_pkg::addr_t  vdata_addr_i,
    input  wire logic                 vdata_we_i,
    input  wire vmem_bus_pkg::be_t    vdata_be_i,
    input  wire vmem_bus_pkg::line_t  vdata_wdata_i,
    input  wire vmem_bus_pkg::vid_t   vdata_id_i,
    output logic                      vdata_gnt_o,
    output logic                      vdata_rvalid_o,
    output vmem_bus_pkg::line_t       vdata_rdata_o,
    output vmem_bus_pkg::vid_t        vdata_rid_o,
    output logic                      vdata_err_o,

    input  wire logic                 pending_load_i,
    input  wire logic                 pending_store_i,

    // memory bus
    output logic                      mem_req_o,
    output vmem_bus_pkg::addr_t       mem_addr_o,
    output logic                      mem_we_o,
    output vmem_bus_pkg::be_t         mem_be_o,
    output vmem_bus_pkg::line_t       mem_wdata_o,
    input  wire logic                 mem_rvalid_i,
    input  wire logic                 mem_err_i,
    input  wire vmem_bus_pkg::line_t  mem_rdata_i
);
    import vmem_bus_pkg::*;

    // merged data port
    logic  data_req;
    addr_t data_addr;
    logic  data_we;
    be_t   data_be;
    line_t data_wdata;
    logic  data_gnt;
    logic  data_rvalid;
    line_t data_rdata;
    logic  bus_err;

    dport_mux u_dport_mux (
        .sdata_req_i     ( sdata_req_i     ),
        .sdata_addr_i    ( sdata_addr_i    ),
        .sdata_we_i      ( sdata_we_i      ),
        .sdata_be_i      ( sdata_be_i      ),
        .sdata_wdata_i   ( sdata_wdata_i   ),
        .vdata_req_i     ( vdata_req_i     ),
        .vdata_addr_i    ( vdata_addr_i    ),
        .vdata_we_i      ( vdata_we_i      ),
        .vdata_be_i      ( vdata_be_i      ),
        .vdata_wdata_i   ( vdata_wdata_i   ),
        .pending_load_i  ( pending_load_i  ),
        .pending_store_i ( pending_store_i ),
        .data_gnt_i      ( data_gnt        ),
        .data_req_o      ( data_req        ),
        .data_addr_o     ( data_addr       ),
        .data_we_o       ( data_we         ),
        .data_be_o       ( data_be         ),
        .data_wdata_o    ( data_wdata      ),
        .sdata_gnt_o     ( sdata_gnt_o     ),
        .vdata_gnt_o     ( vdata_gnt_o     )
    );

    dport_wait_fsm u_dport_wait_fsm (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .sdata_gnt_i    ( sdata_gnt_o    ),
        .vdata_gnt_i    ( vdata_gnt_o    ),
        .sdata_addr_i   ( sdata_addr_i   ),
        .vdata_id_i     ( vdata_id_i     ),
        .data_rvalid_i  ( data_rvalid    ),
        .data_rdata_i   ( data_rdata     ),
        .sdata_rvalid_o ( sdata_rvalid_o ),
        .sdata_rdata_o  ( sdata_rdata_o  ),
        .vdata_rvalid_o ( vdata_rvalid_o ),
        .vdata_rdata_o  ( vdata_rdata_o  ),
        .vdata_rid_o    ( vdata_rid_o    )
    );

    bus_arbiter u_bus_arbiter (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .instr_req_i    ( instr_req_i    ),
        .instr_addr_i   ( instr_addr_i   ),
        .instr_gnt_o    ( instr_gnt_o    ),
        .instr_rvalid_o ( instr_rvalid_o ),
        .instr_rdata_o  ( instr_rdata_o  ),
        .data_req_i     ( data_req       ),
        .data_addr_i    ( data_addr      ),
        .data_we_i      ( data_we        ),
        .data_be_i      ( data_be        ),
        .data_wdata_i   ( data_wdata     ),
        .data_gnt_o     ( data_gnt       ),
        .data_rvalid_o  ( data_rvalid    ),
        .data_rdata_o   ( data_rdata     ),
        .err_o          ( bus_err        ),
        .mem_req_o      ( mem_req_o      ),
        .mem_addr_o     ( mem_addr_o     ),
        .mem_we_o       ( mem_we_o       ),
        .mem_be_o       ( mem_be_o       ),
        .mem_wdata_o    ( mem_wdata_o    ),
        .mem_rvalid_i   ( mem_rvalid_i   ),
        .mem_err_i      ( mem_err_i      ),
        .mem_rdata_i    ( mem_rdata_i    )
    );

    // err is only looked at together with a port's rvalid
    assign instr_err_o = bus_err;
    assign sdata_err_o = bus_err;
    assign vdata_err_o = bus_err;

endmodule

`default_nettype wire

// File: tb_vmem_top.sv
/*
 * testbench of vmem_top with a stimulus table and a shadow array
 * in-order memory model with random latency
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vmem_top;
    import vmem_bus_pkg::*;

    localparam int ROWS = 15;
    localparam int TMO  = 40;   // cycles per wait

    typedef struct packed {
        logic [1:0]  port;   // 0 fetch, 1 scalar, 2 vector, 3 fetch with vector
        logic        we;
        logic [31:0] addr;
        logic [7:0]  be;
        logic [63:0] wdata;
        logic [2:0]  vid;
        logic        pl;
        logic        ps;
        logic        err;
    } row_t;

    typedef struct packed {
        line_t       data;
        logic        err;
        logic [31:0] due;
    } rsp_t;

    logic clk_i, rst_ni;
    logic instr_req_i, instr_gnt_o, instr_rvalid_o, instr_err_o;
    addr_t instr_addr_i;
    word_t instr_rdata_o;
    logic sdata_req_i, sdata_we_i, sdata_gnt_o, sdata_rvalid_o, sdata_err_o;
    addr_t sdata_addr_i;
    logic [3:0] sdata_be_i;
    word_t sdata_wdata_i, sdata_rdata_o;
    logic vdata_req_i, vdata_we_i, vdata_gnt_o, vdata_rvalid_o, vdata_err_o;
    addr_t vdata_addr_i;
    be_t vdata_be_i;
    line_t vdata_wdata_i, vdata_rdata_o;
    vid_t vdata_id_i, vdata_rid_o;
    logic pending_load_i, pending_store_i;
    logic mem_req_o, mem_we_o, mem_rvalid_i, mem_err_i;
    addr_t mem_addr_o;
    be_t mem_be_o;
    line_t mem_wdata_o, mem_rdata_i;

    line_t mem [64];
    line_t shadow [64];
    rsp_t rsp_q [$];
    row_t rows [ROWS];
    logic [31:0] cyc;
    logic err_inj;
    int seed;
    int errs;

    vmem_top u_dut (.*);

    always #5 clk_i = ~clk_i;

    function automatic line_t fill_beat(int i);
        return {32'(i * 8 + 4) ^ 32'h5a5a_0000, 32'(i * 8) ^ 32'ha5a5_0000};
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errs++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        errs++;
    endtask

    ////////////////////
    // memory model accepts at posedge and answers on negedge
    always @(posedge clk_i) begin
        cyc = cyc + 1;
        if (rst_ni && mem_req_o) begin
            for (int b = 0; b < 8; b++) begin
                if (mem_we_o && mem_be_o[b]) begin
                    mem[mem_addr_o[8:3]][b*8 +: 8] = mem_wdata_o[b*8 +: 8];
                end
            end
            rsp_q.push_back({mem[mem_addr_o[8:3]], err_inj, cyc + ({$random(seed)} % 4)});
            assert (rsp_q.size() <= 8) else report_failure("more than 8 requests outstanding");
        end
    end

    always @(negedge clk_i) begin
        mem_rvalid_i = 1'b0;
        mem_err_i    = 1'b0;
        if (rsp_q.size() > 0 && rsp_q[0].due <= cyc) begin
            mem_rvalid_i = 1'b1;
            mem_err_i    = rsp_q[0].err;
            mem_rdata_i  = rsp_q[0].data;
            void'(rsp_q.pop_front());
        end
    end

    ////////////////////
    task automatic run_row(input row_t r, input int n);
        logic       want_f, want_s, want_v;
        logic       gf, gs, gv, rf, rs, rv;
        logic       exp_s, exp_f;
        addr_t      faddr;
        word_t      exp_fw, exp_sw;
        logic [5:0] idx;
        int         e0;
        int         lb;
        e0     = errs;
        idx    = r.addr[8:3];
        want_f = (r.port == 2'd0) || (r.port == 2'd3);
        want_s = (r.port == 2'd1);
        want_v = r.port[1];
        faddr  = (r.port == 2'd3) ? r.addr + 32'd4 : r.addr;
        exp_fw = faddr[2] ? shadow[faddr[8:3]][63:32] : shadow[faddr[8:3]][31:0];
        exp_sw = r.addr[2] ? shadow[idx][63:32] : shadow[idx][31:0];
        @(negedge clk_i);
        err_inj         = r.err;
        pending_load_i  = r.pl;
        pending_store_i = r.ps;
        instr_req_i     = want_f;
        instr_addr_i    = faddr;
        sdata_req_i     = want_s;
        sdata_addr_i    = r.addr;
        sdata_we_i      = r.we;
        sdata_be_i      = r.be[3:0];
        sdata_wdata_i   = r.wdata[31:0];
        vdata_req_i     = want_v;
        vdata_addr_i    = r.addr;
        vdata_we_i      = r.we;
        vdata_be_i      = r.be;
        vdata_wdata_i   = r.wdata;
        vdata_id_i      = r.vid;
        gf = ~want_f;
        gs = ~want_s;
        gv = ~want_v;
        rf = ~want_f;
        rs = ~want_s;
        rv = ~want_v;
        for (int t = 0; t < TMO && !(gf && gs && gv && rf && rs && rv); t++) begin
            if (t == 3) begin
                pending_load_i  = 1'b0;   // release held scalar request
                pending_store_i = 1'b0;
            end
            #4;
            // vector first, then an unheld scalar request, fetch only on an idle data port
            exp_s = sdata_req_i && !vdata_req_i && !pending_store_i
                    && !(pending_load_i && sdata_we_i);
            exp_f = instr_req_i && !vdata_req_i && !exp_s;
            compare_value("instr_gnt_o", 64'(instr_gnt_o), 64'(exp_f));
            compare_value("sdata_gnt_o", 64'(sdata_gnt_o), 64'(exp_s));
            compare_value("vdata_gnt_o", 64'(vdata_gnt_o), 64'(vdata_req_i));
            gf = gf | instr_gnt_o;
            gs = gs | sdata_gnt_o;
            gv = gv | vdata_gnt_o;
            if (instr_rvalid_o) begin
                assert (!rf) else report_failure("unexpected fetch response");
                rf = 1'b1;
                compare_value("instr_rdata_o", 64'(instr_rdata_o), 64'(exp_fw));
                compare_value("instr_err_o", 64'(instr_err_o), 64'(r.err));
            end
            if (sdata_rvalid_o) begin
                assert (!rs) else report_failure("unexpected scalar data response");
                rs = 1'b1;
                if (!r.we) compare_value("sdata_rdata_o", 64'(sdata_rdata_o), 64'(exp_sw));
                compare_value("sdata_err_o", 64'(sdata_err_o), 64'(r.err));
            end
            if (vdata_rvalid_o) begin
                assert (!rv) else report_failure("unexpected vector data response");
                rv = 1'b1;
                if (!r.we) compare_value("vdata_rdata_o", vdata_rdata_o, shadow[idx]);
                compare_value("vdata_rid_o", 64'(vdata_rid_o), 64'(r.vid));
                compare_value("vdata_err_o", 64'(vdata_err_o), 64'(r.err));
            end
            @(negedge clk_i);
            // granted requests drop, address and id move away
            if (gf) begin
                instr_req_i  = 1'b0;
                instr_addr_i = ~faddr;
            end
            if (gs) begin
                sdata_req_i  = 1'b0;
                sdata_addr_i = ~r.addr;
            end
            if (gv) begin
                vdata_req_i = 1'b0;
                vdata_id_i  = ~r.vid;
            end
        end
        err_inj         = 1'b0;
        pending_load_i  = 1'b0;
        pending_store_i = 1'b0;
        assert (gf && gs && gv) else report_failure("request not granted before timeout");
        if (gf && gs && gv) begin
            assert (rf && rs && rv) else report_failure("response not seen before timeout");
        end
        // stores land in the shadow once answered
        for (int b = 0; b < 8; b++) begin
            if (r.we && want_s && b < 4 && r.be[b]) begin
                lb = r.addr[2] ? b + 4 : b;
                shadow[idx][lb*8 +: 8] = r.wdata[b*8 +: 8];
            end
            if (r.we && want_v && r.be[b]) begin
                shadow[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
            end
        end
        $display("row %0d: %s", n, (errs == e0) ? "ok" : "FAIL");
    endtask

    initial begin
        seed = 10527;
        errs = 0;
        cyc = '0;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        {instr_req_i, instr_addr_i, sdata_req_i, sdata_addr_i, sdata_we_i} = '0;
        {sdata_be_i, sdata_wdata_i, vdata_req_i, vdata_addr_i, vdata_we_i} = '0;
        {vdata_be_i, vdata_wdata_i, vdata_id_i, pending_load_i, pending_store_i} = '0;
        {mem_rvalid_i, mem_err_i, mem_rdata_i, err_inj} = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i]    = fill_beat(i);
            shadow[i] = fill_beat(i);
        end
        //         port we addr    be     wdata                  vid pl ps err
        rows[0]  = {2'd0, 1'b0, 32'h10, 8'hff, 64'h0, 3'd0, 1'b0, 1'b0, 1'b0};
        rows[1]  = {2'd0, 1'b0, 32'h1c, 8'hff, 64'h0, 3'd0, 1'b0, 1'b0, 1'b0};
        rows[2]  = {2'd1, 1'b1, 32'h24, 8'h05, 64'hdeadbeef, 3'd0, 1'b0, 1'b0, 1'b0};
        rows[3]  = {2'd1, 1'b0, 32'h24, 8'h0f, 64'h0, 3'd0, 1'b0, 1'b0, 1'b0};
        rows[4]  = {2'd2, 1'b1, 32'h40, 8'hff, 64'h0123_4567_89ab_cdef, 3'd5, 1'b0, 1'b0, 1'b0};
        rows[5]  = {2'd2, 1'b0, 32'h40, 8'hff, 64'h0, 3'd5, 1'b0, 1'b0, 1'b0};
        rows[6]  = {2'd2, 1'b1, 32'h48, 8'h0f, 64'h1111_2222_3333_4444, 3'd2, 1'b0, 1'b0, 1'b0};
        rows[7]  = {2'd2, 1'b0, 32'h48, 8'hff, 64'h0, 3'd3, 1'b0, 1'b0, 1'b0};
        rows[8]  = {2'd3, 1'b0, 32'h40, 8'hff, 64'h0, 3'd6, 1'b0, 1'b0, 1'b0};
        rows[9]  = {2'd1, 1'b1, 32'h30, 8'h0f, 64'hcafe_f00d, 3'd0, 1'b0, 1'b1, 1'b0};
        rows[10] = {2'd1, 1'b0, 32'h34, 8'h0f, 64'h0, 3'd0, 1'b1, 1'b0, 1'b0};
        rows[11] = {2'd1, 1'b1, 32'h34, 8'h0c, 64'h5566_7788, 3'd0, 1'b1, 1'b0, 1'b0};
        rows[12] = {2'd1, 1'b0, 32'h34, 8'h0f, 64'h0, 3'd0, 1'b0, 1'b0, 1'b1};
        rows[13] = {2'd2, 1'b0, 32'h08, 8'hff, 64'h0, 3'd1, 1'b0, 1'b0, 1'b1};
        rows[14] = {2'd0, 1'b0, 32'h30, 8'hff, 64'h0, 3'd0, 1'b0, 1'b0, 1'b1};
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int n = 0; n < ROWS; n++) run_row(rows[n], n);
        $display("tests %0d, errors %0d", ROWS, errs);
        if (errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vmem_top.f
+incdir+.
vmem_bus_pkg.sv
vmem_ctrl_pkg.sv
dport_mux.sv
dport_wait_fsm.sv
req_counter.sv
bus_arbiter.sv
vmem_top.sv
tb_vmem_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vmem_top.f --top-module tb_vmem_top -Mdir obj_dir
./obj_dir/Vtb_vmem_top > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
exit 0
